// File: hw/pad_pkg.sv
// Pad subsystem shared definitions
// Register widths, register map, pin mux sources and pad attributes
`default_nettype none

package pad_pkg;

  // Register port widths
  localparam int unsigned DataW = 16;
  localparam int unsigned AddrW = 4;

  // Per-pad attribute vector
  localparam int unsigned AttrDw     = 2;
  localparam int unsigned AttrInvBit = 0;
  localparam int unsigned AttrOdBit  = 1;

  // Two select bits per pad in one data word
  localparam int unsigned MaxPads = DataW / 2;

  //////////////////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////////////////

  typedef enum logic [AddrW-1:0] {
    REG_GPIO_OUT   = 4'd0,
    REG_GPIO_OE    = 4'd1,
    REG_GPIO_IN    = 4'd2,  // read only
    REG_PWM_PERIOD = 4'd3,
    REG_PWM_DUTY   = 4'd4,
    REG_MUX_SEL    = 4'd5,
    REG_PAD_INV    = 4'd6,
    REG_PAD_OD     = 4'd7
  } reg_addr_e;

  //////////////////////////////////////////////////////////////
  // Pin mux sources
  //////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    MUX_GPIO = 2'd0,
    MUX_PWM  = 2'd1,
    MUX_OFF  = 2'd2,
    MUX_RSVD = 2'd3   // treated as off
  } mux_sel_e;

endpackage

`default_nettype wire

// File: hw/pad_cell.sv
// Bidirectional pad cell
// Inverts both directions, drives push-pull or open-drain
`default_nettype none

module pad_cell (
  input  wire  out_i,
  input  wire  oe_i,
  input  wire  inv_i,
  input  wire  od_i,
  output logic in_o,
  inout  wire  pad_io
);

  logic out_inv;
  logic drive_en;

  // Level presented at the pin
  assign out_inv = out_i ^ inv_i;

  // Open drain only ever pulls low
  assign drive_en = oe_i & (~od_i | ~out_inv);

  assign pad_io = drive_en ? out_inv : 1'bz;

  // Input path sees the same inversion
  assign in_o = pad_io ^ inv_i;

endmodule

`default_nettype wire

// File: hw/padring.sv
// Pad ring
// One pad cell per pad, masked pads tied off in both directions
`default_nettype none

module padring #(
  parameter int unsigned        NumPads    = 8,
  parameter logic [NumPads-1:0] ConnectIn  = '1,
  parameter logic [NumPads-1:0] ConnectOut = '1
) (
  input  wire  [NumPads-1:0] core_out_i,
  input  wire  [NumPads-1:0] core_oe_i,
  input  wire  [NumPads-1:0] pad_inv_i,
  input  wire  [NumPads-1:0] pad_od_i,
  output logic [NumPads-1:0] core_in_o,
  inout  wire  [NumPads-1:0] pads_io
);

  import pad_pkg::*;

  logic [NumPads-1:0][AttrDw-1:0] pad_attr;
  logic [NumPads-1:0]             cell_oe;
  logic [NumPads-1:0]             cell_in;

  for (genvar i = 0; i < NumPads; i++) begin : gen_pads
    // Attribute vector per pad
    assign pad_attr[i][AttrInvBit] = pad_inv_i[i];
    assign pad_attr[i][AttrOdBit]  = pad_od_i[i];

    // Unconnected outputs never enable
    assign cell_oe[i] = ConnectOut[i] ? core_oe_i[i] : 1'b0;

    pad_cell pad_cell_i (
      .out_i  ( core_out_i[i]            ),
      .oe_i   ( cell_oe[i]               ),
      .inv_i  ( pad_attr[i][AttrInvBit]  ),
      .od_i   ( pad_attr[i][AttrOdBit]   ),
      .in_o   ( cell_in[i]               ),
      .pad_io ( pads_io[i]               )
    );

    // Unconnected inputs read as zero
    assign core_in_o[i] = ConnectIn[i] ? cell_in[i] : 1'b0;
  end

endmodule

`default_nettype wire

// File: hw/pinmux.sv
// Pin multiplexer
// Picks output and output enable per pad from GPIO, PWM or off
`default_nettype none

module pinmux #(
  parameter int unsigned NumPads = 8
) (
  input  wire  [NumPads-1:0]   gpio_out_i,
  input  wire  [NumPads-1:0]   gpio_oe_i,
  input  wire                  pwm_i,
  input  wire  [2*NumPads-1:0] mux_sel_i,
  output logic [NumPads-1:0]   core_out_o,
  output logic [NumPads-1:0]   core_oe_o
);

  import pad_pkg::*;

  mux_sel_e pad_sel [NumPads];

  // Two select bits per pad, pad 0 in the low bits
  for (genvar i = 0; i < NumPads; i++) begin : gen_sel
    assign pad_sel[i] = mux_sel_e'(mux_sel_i[2*i +: 2]);
  end

  always_comb begin
    for (int unsigned i = 0; i < NumPads; i++) begin
      case (pad_sel[i])
        MUX_GPIO: begin
          core_out_o[i] = gpio_out_i[i];
          core_oe_o[i]  = gpio_oe_i[i];
        end
        MUX_PWM: begin
          core_out_o[i] = pwm_i;
          core_oe_o[i]  = 1'b1;
        end
        // Off and reserved leave the pad undriven
        default: begin
          core_out_o[i] = 1'b0;
          core_oe_o[i]  = 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/pwm_gen.sv
// PWM generator
// Free-running counter, wraps at period, high while below duty
`default_nettype none

module pwm_gen (
  input  wire                      clk_main_i,
  input  wire                      rst_i,
  input  wire [pad_pkg::DataW-1:0] period_i,
  input  wire [pad_pkg::DataW-1:0] duty_i,
  output logic                     pwm_o
);

  import pad_pkg::*;

  logic [DataW-1:0] cnt_q;
  logic [DataW-1:0] cnt_d;
  logic             cnt_wrap;
  logic             pwm_q;

  // Also wraps if period drops below the running count
  assign cnt_wrap = (cnt_q >= period_i);

  always_comb begin
    if (cnt_wrap) begin
      cnt_d = '0;
    end else begin
      cnt_d = cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_main_i) begin
    if (rst_i) begin
      cnt_q <= '0;
      pwm_q <= 1'b0;
    end else begin
      cnt_q <= cnt_d;
      pwm_q <= (cnt_q < duty_i);
    end
  end

  assign pwm_o = pwm_q;

  // Count stays within the larger of period and its last value
  a_cnt_bound: assert property (@(posedge clk_main_i) disable iff (rst_i)
    cnt_q <= (($past(period_i) > $past(cnt_q)) ? $past(period_i) : $past(cnt_q)))
    else $error("pwm_gen: counter ran past period");

endmodule

`default_nettype wire

// File: hw/chip_regs.sv
// Configuration registers
// Single-outstanding request/response port, GPIO input synchronizer
`default_nettype none

module chip_regs #(
  parameter int unsigned NumPads = 8
) (
  input  wire                        clk_main_i,
  input  wire                        rst_i,
  // Request channel
  input  wire                        req_valid_i,
  output logic                       req_ready_o,
  input  wire                        req_write_i,
  input  wire pad_pkg::reg_addr_e    req_addr_i,
  input  wire  [pad_pkg::DataW-1:0]  req_wdata_i,
  // Response channel
  output logic                       rsp_valid_o,
  input  wire                        rsp_ready_i,
  output logic [pad_pkg::DataW-1:0]  rsp_rdata_o,
  output logic                       rsp_error_o,
  // Core side
  input  wire  [NumPads-1:0]         core_in_i,
  output logic [NumPads-1:0]         gpio_out_o,
  output logic [NumPads-1:0]         gpio_oe_o,
  output logic [pad_pkg::DataW-1:0]  pwm_period_o,
  output logic [pad_pkg::DataW-1:0]  pwm_duty_o,
  output logic [2*NumPads-1:0]       mux_sel_o,
  output logic [NumPads-1:0]         pad_inv_o,
  output logic [NumPads-1:0]         pad_od_o
);

  import pad_pkg::*;

  logic               req_fire;
  logic               rsp_fire;
  logic               busy_q;
  logic               rsp_valid_q;
  logic               addr_mapped;
  logic               req_err;
  reg_addr_e          acc_addr_q;
  logic               acc_write_q;
  logic               acc_err_q;
  logic [DataW-1:0]   rdata_d;
  logic [DataW-1:0]   rsp_rdata_q;
  logic               rsp_error_q;
  logic [NumPads-1:0] gpio_out_q;
  logic [NumPads-1:0] gpio_oe_q;
  logic [DataW-1:0]   period_q;
  logic [DataW-1:0]   duty_q;
  logic [2*NumPads-1:0] mux_sel_q;
  logic [NumPads-1:0] pad_inv_q;
  logic [NumPads-1:0] pad_od_q;
  logic [NumPads-1:0] in_q;
  logic [NumPads-1:0] sync1_q;
  logic [NumPads-1:0] sync2_q;

  //////////////////////////////////////////////////////////////
  // Request decode
  //////////////////////////////////////////////////////////////

  // Stalled from accept until the response completes
  assign req_ready_o = ~busy_q & ~rsp_valid_q;
  assign req_fire    = req_valid_i & req_ready_o;
  assign rsp_fire    = rsp_valid_q & rsp_ready_i;

  always_comb begin
    case (req_addr_i)
      REG_GPIO_OUT, REG_GPIO_OE, REG_GPIO_IN, REG_PWM_PERIOD,
      REG_PWM_DUTY, REG_MUX_SEL, REG_PAD_INV, REG_PAD_OD: addr_mapped = 1'b1;
      default: addr_mapped = 1'b0;
    endcase
  end

  // GPIO_IN is read only
  assign req_err = ~addr_mapped | (req_write_i & (req_addr_i == REG_GPIO_IN));

  //////////////////////////////////////////////////////////////
  // Configuration registers
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk_main_i) begin
    if (rst_i) begin
      gpio_out_q <= '0;
      gpio_oe_q  <= '0;
      period_q   <= '0;
      duty_q     <= '0;
      mux_sel_q  <= '0;
      pad_inv_q  <= '0;
      pad_od_q   <= '0;
    end else if (req_fire && req_write_i && !req_err) begin
      case (req_addr_i)
        REG_GPIO_OUT:   gpio_out_q <= req_wdata_i[NumPads-1:0];
        REG_GPIO_OE:    gpio_oe_q  <= req_wdata_i[NumPads-1:0];
        REG_PWM_PERIOD: period_q   <= req_wdata_i;
        REG_PWM_DUTY:   duty_q     <= req_wdata_i;
        REG_MUX_SEL:    mux_sel_q  <= req_wdata_i[2*NumPads-1:0];
        REG_PAD_INV:    pad_inv_q  <= req_wdata_i[NumPads-1:0];
        REG_PAD_OD:     pad_od_q   <= req_wdata_i[NumPads-1:0];
        default: ;
      endcase
    end
  end

  // Input register then two sync flops
  always_ff @(posedge clk_main_i) begin
    if (rst_i) begin
      in_q    <= '0;
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      in_q    <= core_in_i;
      sync1_q <= in_q;
      sync2_q <= sync1_q;
    end
  end

  //////////////////////////////////////////////////////////////
  // Response
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk_main_i) begin
    if (rst_i) begin
      busy_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      busy_q <= req_fire;
      if (busy_q) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_fire) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_main_i) begin
    if (req_fire) begin
      acc_addr_q  <= req_addr_i;
      acc_write_q <= req_write_i;
      acc_err_q   <= req_err;
    end
  end

  // Read data mux, sampled one cycle after accept
  always_comb begin
    rdata_d = '0;
    case (acc_addr_q)
      REG_GPIO_OUT:   rdata_d[NumPads-1:0]   = gpio_out_q;
      REG_GPIO_OE:    rdata_d[NumPads-1:0]   = gpio_oe_q;
      REG_GPIO_IN:    rdata_d[NumPads-1:0]   = sync2_q;
      REG_PWM_PERIOD: rdata_d                = period_q;
      REG_PWM_DUTY:   rdata_d                = duty_q;
      REG_MUX_SEL:    rdata_d[2*NumPads-1:0] = mux_sel_q;
      REG_PAD_INV:    rdata_d[NumPads-1:0]   = pad_inv_q;
      REG_PAD_OD:     rdata_d[NumPads-1:0]   = pad_od_q;
      default: ;
    endcase
  end

  always_ff @(posedge clk_main_i) begin
    if (busy_q) begin
      rsp_rdata_q <= (acc_write_q || acc_err_q) ? '0 : rdata_d;
      rsp_error_q <= acc_err_q;
    end
  end

  assign rsp_valid_o  = rsp_valid_q;
  assign rsp_rdata_o  = rsp_rdata_q;
  assign rsp_error_o  = rsp_error_q;
  assign gpio_out_o   = gpio_out_q;
  assign gpio_oe_o    = gpio_oe_q;
  assign pwm_period_o = period_q;
  assign pwm_duty_o   = duty_q;
  assign mux_sel_o    = mux_sel_q;
  assign pad_inv_o    = pad_inv_q;
  assign pad_od_o     = pad_od_q;

  // Held response keeps its contents
  a_rsp_hold: assert property (@(posedge clk_main_i) disable iff (rst_i)
    rsp_valid_o && !rsp_ready_i |=>
      rsp_valid_o && $stable(rsp_rdata_o) && $stable(rsp_error_o))
    else $error("chip_regs: response changed under back-pressure");

  // No new accept from the accepting edge until the response completes
  a_one_outstanding: assert property (@(posedge clk_main_i) disable iff (rst_i)
    $past(req_valid_i && req_ready_o) || rsp_valid_o |-> !req_ready_o)
    else $error("chip_regs: request accepted with a response pending");

endmodule

`default_nettype wire

// File: hw/chip_top.sv
// Chip top level
// Registers, PWM, pin mux and pad ring wired out to the board pins
`default_nettype none

module chip_top #(
  parameter int unsigned        NumPads    = 8,
  parameter logic [NumPads-1:0] ConnectIn  = '1,
  parameter logic [NumPads-1:0] ConnectOut = '1
) (
  input  wire                        clk_main_i,
  input  wire                        rst_i,
  // Register port
  input  wire                        req_valid_i,
  output logic                       req_ready_o,
  input  wire                        req_write_i,
  input  wire pad_pkg::reg_addr_e    req_addr_i,
  input  wire  [pad_pkg::DataW-1:0]  req_wdata_i,
  output logic                       rsp_valid_o,
  input  wire                        rsp_ready_i,
  output logic [pad_pkg::DataW-1:0]  rsp_rdata_o,
  output logic                       rsp_error_o,
  // Board pins
  inout  wire  [NumPads-1:0]         pads_io
);

  import pad_pkg::*;

  // Select register only holds MaxPads fields
  if (NumPads > MaxPads) begin : gen_pad_count_check
    $error("chip_top: NumPads %0d exceeds %0d", NumPads, MaxPads);
  end

  logic [NumPads-1:0]   gpio_out;
  logic [NumPads-1:0]   gpio_oe;
  logic [DataW-1:0]     pwm_period;
  logic [DataW-1:0]     pwm_duty;
  logic [2*NumPads-1:0] mux_sel;
  logic [NumPads-1:0]   pad_inv;
  logic [NumPads-1:0]   pad_od;
  logic                 pwm_out;
  logic [NumPads-1:0]   core_out;
  logic [NumPads-1:0]   core_oe;
  logic [NumPads-1:0]   core_in;

  //////////////////////////////////////////////////////////////
  // Core blocks
  //////////////////////////////////////////////////////////////

  chip_regs #(
    .NumPads ( NumPads )
  ) chip_regs_i (
    .clk_main_i   ( clk_main_i  ),
    .rst_i        ( rst_i       ),
    .req_valid_i  ( req_valid_i ),
    .req_ready_o  ( req_ready_o ),
    .req_write_i  ( req_write_i ),
    .req_addr_i   ( req_addr_i  ),
    .req_wdata_i  ( req_wdata_i ),
    .rsp_valid_o  ( rsp_valid_o ),
    .rsp_ready_i  ( rsp_ready_i ),
    .rsp_rdata_o  ( rsp_rdata_o ),
    .rsp_error_o  ( rsp_error_o ),
    .core_in_i    ( core_in     ),
    .gpio_out_o   ( gpio_out    ),
    .gpio_oe_o    ( gpio_oe     ),
    .pwm_period_o ( pwm_period  ),
    .pwm_duty_o   ( pwm_duty    ),
    .mux_sel_o    ( mux_sel     ),
    .pad_inv_o    ( pad_inv     ),
    .pad_od_o     ( pad_od      )
  );

  pwm_gen pwm_gen_i (
    .clk_main_i ( clk_main_i ),
    .rst_i      ( rst_i      ),
    .period_i   ( pwm_period ),
    .duty_i     ( pwm_duty   ),
    .pwm_o      ( pwm_out    )
  );

  pinmux #(
    .NumPads ( NumPads )
  ) pinmux_i (
    .gpio_out_i ( gpio_out ),
    .gpio_oe_i  ( gpio_oe  ),
    .pwm_i      ( pwm_out  ),
    .mux_sel_i  ( mux_sel  ),
    .core_out_o ( core_out ),
    .core_oe_o  ( core_oe  )
  );

  //////////////////////////////////////////////////////////////
  // Pad ring
  //////////////////////////////////////////////////////////////

  padring #(
    .NumPads    ( NumPads    ),
    .ConnectIn  ( ConnectIn  ),
    .ConnectOut ( ConnectOut )
  ) padring_i (
    .core_out_i ( core_out ),
    .core_oe_i  ( core_oe  ),
    .pad_inv_i  ( pad_inv  ),
    .pad_od_i   ( pad_od   ),
    .core_in_o  ( core_in  ),
    .pads_io    ( pads_io  )
  );

endmodule

`default_nettype wire

// File: testbench/tb_chip_top.sv
// Testbench for the pad subsystem top level
// Random register traffic, pad levels and PWM checked against a register model
`default_nettype none

module tb_chip_top;

  timeunit 1ns;
  timeprecision 1ps;

  import pad_pkg::*;

  localparam int unsigned        NumPads     = 8;
  localparam logic [NumPads-1:0] ConnectMask = 8'h7F;
  localparam int unsigned        Timeout     = 200;

  logic               clk_main_i;
  logic               rst_i;
  logic               req_valid_i;
  logic               req_ready_o;
  logic               req_write_i;
  reg_addr_e          req_addr_i;
  logic [DataW-1:0]   req_wdata_i;
  logic               rsp_valid_o;
  logic               rsp_ready_i;
  logic [DataW-1:0]   rsp_rdata_o;
  logic               rsp_error_o;
  tri1  [NumPads-1:0] pads_io;
  logic [NumPads-1:0] ext_oe;
  logic [NumPads-1:0] ext_lvl;

  // Register model
  logic [NumPads-1:0]   m_gpio_out;
  logic [NumPads-1:0]   m_gpio_oe;
  logic [DataW-1:0]     m_period;
  logic [DataW-1:0]     m_duty;
  logic [2*NumPads-1:0] m_mux_sel;
  logic [NumPads-1:0]   m_pad_inv;
  logic [NumPads-1:0]   m_pad_od;

  logic [31:0] rng_state;
  int unsigned err_count;
  int unsigned timeout_count;

  reg_addr_e writable [7] = '{REG_GPIO_OUT, REG_GPIO_OE, REG_PWM_PERIOD, REG_PWM_DUTY,
                              REG_MUX_SEL, REG_PAD_INV, REG_PAD_OD};

  chip_top #(
    .NumPads    ( NumPads     ),
    .ConnectIn  ( ConnectMask ),
    .ConnectOut ( ConnectMask )
  ) chip_top_i (
    .clk_main_i  ( clk_main_i  ),
    .rst_i       ( rst_i       ),
    .req_valid_i ( req_valid_i ),
    .req_ready_o ( req_ready_o ),
    .req_write_i ( req_write_i ),
    .req_addr_i  ( req_addr_i  ),
    .req_wdata_i ( req_wdata_i ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_ready_i ( rsp_ready_i ),
    .rsp_rdata_o ( rsp_rdata_o ),
    .rsp_error_o ( rsp_error_o ),
    .pads_io     ( pads_io     )
  );

  // External drivers on the board side, pull-ups otherwise
  for (genvar i = 0; i < NumPads; i++) begin : gen_ext_drv
    assign pads_io[i] = ext_oe[i] ? ext_lvl[i] : 1'bz;
  end

  always #5 clk_main_i = ~clk_main_i;

  function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  //////////////////////////////////////////////////////////////
  // Model
  //////////////////////////////////////////////////////////////

  function automatic void model_write(input reg_addr_e addr, input logic [DataW-1:0] d);
    case (addr)
      REG_GPIO_OUT:   m_gpio_out = d[NumPads-1:0];
      REG_GPIO_OE:    m_gpio_oe  = d[NumPads-1:0];
      REG_PWM_PERIOD: m_period   = d;
      REG_PWM_DUTY:   m_duty     = d;
      REG_MUX_SEL:    m_mux_sel  = d[2*NumPads-1:0];
      REG_PAD_INV:    m_pad_inv  = d[NumPads-1:0];
      REG_PAD_OD:     m_pad_od   = d[NumPads-1:0];
      default: ;
    endcase
  endfunction

  function automatic logic [DataW-1:0] model_read(input reg_addr_e addr);
    logic [DataW-1:0] rd;
    rd = '0;
    case (addr)
      REG_GPIO_OUT:   rd[NumPads-1:0]   = m_gpio_out;
      REG_GPIO_OE:    rd[NumPads-1:0]   = m_gpio_oe;
      REG_PWM_PERIOD: rd                = m_period;
      REG_PWM_DUTY:   rd                = m_duty;
      REG_MUX_SEL:    rd[2*NumPads-1:0] = m_mux_sel;
      REG_PAD_INV:    rd[NumPads-1:0]   = m_pad_inv;
      REG_PAD_OD:     rd[NumPads-1:0]   = m_pad_od;
      default: ;
    endcase
    return rd;
  endfunction

  // Output enable as seen at the pin, masked pads never drive
  function automatic logic model_oe(input int i);
    mux_sel_e sel;
    sel = mux_sel_e'(m_mux_sel[2*i +: 2]);
    if (!ConnectMask[i]) return 1'b0;
    case (sel)
      MUX_GPIO: return m_gpio_oe[i];
      MUX_PWM:  return 1'b1;
      default:  return 1'b0;
    endcase
  endfunction

  function automatic logic model_pad(input int i, input logic pwm_lvl);
    logic lvl;
    lvl = (mux_sel_e'(m_mux_sel[2*i +: 2]) == MUX_PWM) ? pwm_lvl : m_gpio_out[i];
    lvl = lvl ^ m_pad_inv[i];
    // Released open drain and undriven pads sit at the pull-up
    if (!model_oe(i) || (m_pad_od[i] && lvl)) return 1'b1;
    return lvl;
  endfunction

  //////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////

  task automatic check_rdata(input string name, input logic [DataW-1:0] exp,
                             input logic [DataW-1:0] act);
    if (act !== exp) begin
      err_count++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_error(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_count++;
      $display("[ERROR] %s error flag: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_pad(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_count++;
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_all_pads(input string name, input logic pwm_lvl);
    for (int i = 0; i < NumPads; i++) begin
      check_pad($sformatf("%s pad %0d", name, i), model_pad(i, pwm_lvl), pads_io[i]);
    end
  endtask

  //////////////////////////////////////////////////////////////
  // Register port
  //////////////////////////////////////////////////////////////

  task automatic wait_cycles(input int n);
    for (int c = 0; c < n; c++) begin
      @(posedge clk_main_i);
    end
  endtask

  // One request, then the response under random back-pressure
  task automatic transfer(input string name, input logic wr, input reg_addr_e addr,
                          input logic [DataW-1:0] wdata,
                          output logic [DataW-1:0] rdata, output logic err);
    int unsigned n;
    logic        done;
    logic [31:0] r;
    rdata = '0;
    err   = 1'b0;
    done  = 1'b0;
    @(posedge clk_main_i);
    req_valid_i <= 1'b1;
    req_write_i <= wr;
    req_addr_i  <= addr;
    req_wdata_i <= wdata;
    @(negedge clk_main_i);
    n = 0;
    while (!req_ready_o && n < Timeout) begin
      @(negedge clk_main_i);
      n++;
    end
    if (!req_ready_o) begin
      timeout_count++;
      $display("Timeout in %s: request was never accepted", name);
    end
    @(posedge clk_main_i);
    req_valid_i <= 1'b0;
    n = 0;
    while (!done && n < Timeout) begin
      @(posedge clk_main_i);
      r = xorshift();
      rsp_ready_i <= (r[1:0] != 2'd0);
      @(negedge clk_main_i);
      // Response is valid from the edge after accept and holds the port stalled
      if (req_ready_o !== 1'b0 || rsp_valid_o !== 1'b1) begin
        err_count++;
        $display("[ERROR] %s handshake: expected ready 0 valid 1, actual ready %b valid %b",
                 name, req_ready_o, rsp_valid_o);
      end
      if (rsp_valid_o && rsp_ready_i) begin
        rdata = rsp_rdata_o;
        err   = rsp_error_o;
        done  = 1'b1;
      end
      n++;
    end
    if (!done) begin
      timeout_count++;
      $display("Timeout in %s: no response arrived", name);
    end
    @(posedge clk_main_i);
    rsp_ready_i <= 1'b0;
  endtask

  task automatic write_reg(input reg_addr_e addr, input logic [DataW-1:0] d);
    logic [DataW-1:0] rd;
    logic             er;
    transfer("write", 1'b1, addr, d, rd, er);
    check_error($sformatf("write %s", addr.name()), 1'b0, er);
    check_rdata($sformatf("write %s", addr.name()), '0, rd);
    model_write(addr, d);
  endtask

  task automatic read_check(input string name, input reg_addr_e addr,
                            input logic [DataW-1:0] exp);
    logic [DataW-1:0] rd;
    logic             er;
    transfer(name, 1'b0, addr, '0, rd, er);
    check_error(name, 1'b0, er);
    check_rdata(name, exp, rd);
  endtask

  task automatic check_bad_access(input string name, input logic wr, input reg_addr_e addr,
                                  input logic [DataW-1:0] wdata);
    logic [DataW-1:0] rd;
    logic             er;
    transfer(name, wr, addr, wdata, rd, er);
    check_error(name, 1'b1, er);
    check_rdata(name, '0, rd);
  endtask

  //////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////

  task automatic test_readback();
    logic [31:0] r;
    reg_addr_e   a;
    for (int k = 0; k < 40; k++) begin
      r = xorshift();
      a = writable[r[10:8] % 7];
      write_reg(a, r[31:16]);
      read_check($sformatf("readback %s", a.name()), a, model_read(a));
    end
    for (int k = 0; k < 8; k++) begin
      r = xorshift();
      a = reg_addr_e'(4'd8 + 4'(r % 8));
      check_bad_access("unmapped access", r[8], a, r[31:16]);
    end
    r = xorshift();
    check_bad_access("write gpio_in", 1'b1, REG_GPIO_IN, r[15:0]);
    foreach (writable[k]) begin
      read_check($sformatf("unchanged %s", writable[k].name()), writable[k],
                 model_read(writable[k]));
    end
  endtask

  // PWM parked low with period and duty zero
  task automatic test_pads(input string name, input logic with_attr);
    logic [31:0] r;
    write_reg(REG_PWM_PERIOD, '0);
    write_reg(REG_PWM_DUTY, '0);
    for (int k = 0; k < 20; k++) begin
      r = xorshift();
      write_reg(REG_GPIO_OUT, r[15:0]);
      write_reg(REG_GPIO_OE, r[31:16]);
      r = xorshift();
      write_reg(REG_MUX_SEL, r[15:0]);
      write_reg(REG_PAD_INV, with_attr ? r[23:16] : 16'h0);
      write_reg(REG_PAD_OD, with_attr ? r[31:24] : 16'h0);
      wait_cycles(1);
      @(negedge clk_main_i);
      check_all_pads(name, 1'b0);
    end
  endtask

  task automatic test_gpio_in();
    logic [31:0]        r;
    logic [NumPads-1:0] oe_v;
    logic [NumPads-1:0] lvl_v;
    logic [DataW-1:0]   exp;
    for (int k = 0; k < 10; k++) begin
      r = xorshift();
      write_reg(REG_GPIO_OUT, r[15:0]);
      write_reg(REG_GPIO_OE, r[31:16]);
      r = xorshift();
      write_reg(REG_MUX_SEL, r[15:0]);
      write_reg(REG_PAD_INV, r[23:16]);
      write_reg(REG_PAD_OD, r[31:24]);
      r = xorshift();
      exp = '0;
      for (int i = 0; i < NumPads; i++) begin
        oe_v[i]  = !model_oe(i);
        lvl_v[i] = r[i];
        if (ConnectMask[i]) begin
          exp[i] = (oe_v[i] ? lvl_v[i] : model_pad(i, 1'b0)) ^ m_pad_inv[i];
        end
      end
      @(posedge clk_main_i);
      ext_oe  <= oe_v;
      ext_lvl <= lvl_v;
      wait_cycles(5);
      read_check("gpio_in", REG_GPIO_IN, exp);
      @(posedge clk_main_i);
      ext_oe <= '0;
    end
  endtask

  task automatic test_pwm();
    logic [31:0]          r;
    int unsigned          period;
    int unsigned          duty;
    int unsigned          p;
    int unsigned          high;
    int unsigned          exp;
    logic [2*NumPads-1:0] sel;
    for (int k = 0; k < 8; k++) begin
      r      = xorshift();
      period = r[4:0];
      duty   = r[13:8] % 40;
      p      = r[23:16] % 7;
      for (int i = 0; i < NumPads; i++) begin
        sel[2*i +: 2] = (i == p) ? MUX_PWM : MUX_OFF;
      end
      write_reg(REG_PAD_OD, '0);
      write_reg(REG_PAD_INV, 16'(r[24]) << p);
      write_reg(REG_MUX_SEL, sel);
      write_reg(REG_PWM_PERIOD, 16'(period));
      write_reg(REG_PWM_DUTY, 16'(duty));
      wait_cycles(40);
      high = 0;
      for (int c = 0; c <= period; c++) begin
        @(negedge clk_main_i);
        if (pads_io[p] === 1'b1) high++;
      end
      exp = (duty < period + 1) ? duty : period + 1;
      if (r[24]) exp = period + 1 - exp;
      check_rdata($sformatf("pwm high count pad %0d", p), 16'(exp), 16'(high));
    end
  endtask

  initial begin
    clk_main_i    = 1'b0;
    rst_i         = 1'b1;
    req_valid_i   = 1'b0;
    req_write_i   = 1'b0;
    req_addr_i    = REG_GPIO_OUT;
    req_wdata_i   = '0;
    rsp_ready_i   = 1'b0;
    ext_oe        = '0;
    ext_lvl       = '0;
    rng_state     = 32'd47;
    err_count     = 0;
    timeout_count = 0;
    model_write(REG_GPIO_OUT, '0);
    model_write(REG_GPIO_OE, '0);
    model_write(REG_PWM_PERIOD, '0);
    model_write(REG_PWM_DUTY, '0);
    model_write(REG_MUX_SEL, '0);
    model_write(REG_PAD_INV, '0);
    model_write(REG_PAD_OD, '0);

    wait_cycles(16);
    rst_i <= 1'b0;
    @(negedge clk_main_i);
    if (req_ready_o !== 1'b1 || rsp_valid_o !== 1'b0) begin
      err_count++;
      $display("[ERROR] reset handshake: expected ready 1 valid 0, actual ready %b valid %b",
               req_ready_o, rsp_valid_o);
    end
    check_all_pads("reset", 1'b0);

    test_readback();
    test_pads("gpio mux", 1'b0);
    test_pads("attributes", 1'b1);
    test_gpio_in();
    test_pwm();

    $display("Run complete: %0d errors, %0d timeouts", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
hw/pad_pkg.sv
hw/pad_cell.sv
hw/padring.sv
hw/pinmux.sv
hw/pwm_gen.sv
hw/chip_regs.sv
hw/chip_top.sv
testbench/tb_chip_top.sv
